/* rtl/dcache_geom_pkg.sv */
`default_nettype none

package dcache_geom_pkg;

    localparam int xlen     = 32;   // address and data word width
    localparam int blk_bits = 64;   // one cache block
    localparam int off_bits = 3;    // byte offset inside a block
    localparam int n_lines  = 32;
    localparam int idx_bits = 5;
    localparam int tag_bits = xlen - idx_bits - off_bits;   // 24

    // one block, seen three ways
    // stores write through the view of their size and loads read
    // through theirs, so a byte store lands inside a later word load
    typedef union packed {
        logic [blk_bits/8-1:0][7:0]   bytes;
        logic [blk_bits/16-1:0][15:0] halves;
        logic [blk_bits/32-1:0][31:0] words;
    } cache_block_t;

    // 1 + 1 + 24 + 64 = 90 bits
    typedef struct packed {
        logic                valid;
        logic                dirty;    // block differs from memory
        logic [tag_bits-1:0] tag;
        cache_block_t        block;
    } cache_line_t;

endpackage

`default_nettype wire

/* rtl/mem_bus_pkg.sv */
`default_nettype none

package mem_bus_pkg;

    localparam int mem_tag_bits = 4;   // response and data tags, zero means none

    // command towards memory
    typedef enum logic [1:0] {
        bus_none  = 2'h0,
        bus_load  = 2'h1,
        bus_store = 2'h2
    } bus_cmd_t;

    // pipeline request operation
    typedef enum logic {
        mem_read  = 1'b0,
        mem_write = 1'b1
    } mem_op_t;

    // access size, value 3 is not used
    typedef enum logic [1:0] {
        size_byte = 2'h0,
        size_half = 2'h1,
        size_word = 2'h2
    } mem_size_t;

endpackage

`default_nettype wire

/* rtl/line_ctrl_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface line_ctrl_if;

    // from the state machine
    logic capture;    // latch the incoming request as pending
    logic fill;       // write returned block into the pending line
    logic clean;      // clear dirty at the selected index
    logic use_walk;   // select flush index over pending index

    // from the line store
    logic                                hit;            // live hit of the incoming request
    logic                                victim_dirty;
    logic [dcache_geom_pkg::xlen-1:0]    victim_addr;    // block address, offset bits zero
    dcache_geom_pkg::cache_block_t       victim_data;
    logic [dcache_geom_pkg::xlen-1:0]    pend_addr;

    modport ctrl (
        output capture, fill, clean, use_walk,
        input  hit, victim_dirty, victim_addr, victim_data, pend_addr
    );

    modport store (
        input  capture, fill, clean, use_walk,
        output hit, victim_dirty, victim_addr, victim_data, pend_addr
    );

endinterface

`default_nettype wire

/* rtl/dcache_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache_ctrl (
    input  logic                                     clock,
    input  logic                                     reset,
    input  logic                                     req_valid,
    input  logic                                     done,
    input  logic [mem_bus_pkg::mem_tag_bits-1:0]     mem_response,
    input  logic [mem_bus_pkg::mem_tag_bits-1:0]     mem_tag,
    output logic                                     stall,
    output mem_bus_pkg::bus_cmd_t                    mem_cmd,
    output logic [dcache_geom_pkg::xlen-1:0]         mem_addr,
    output logic [dcache_geom_pkg::blk_bits-1:0]     mem_wdata,
    output logic                                     flush_finished,
    output logic                                     step,
    input  logic [dcache_geom_pkg::idx_bits-1:0]     walk_idx,
    input  logic                                     last,
    line_ctrl_if.ctrl                                lines
);

    typedef enum logic [2:0] {
        st_ready,
        st_write_back,
        st_fetch,
        st_wait_fill,
        st_flush_scan,
        st_flush_store,
        st_finished
    } state_t;

    state_t                                  state;
    state_t                                  state_next;
    logic [mem_bus_pkg::mem_tag_bits-1:0]    kept_tag;   // tag of the accepted load
    logic                                    accepted;

    assign accepted = mem_response != '0;   // zero response is back-pressure

    always_comb begin
        state_next    = state;
        lines.capture = 1'b0;
        lines.fill    = 1'b0;
        lines.clean   = 1'b0;
        step          = 1'b0;
        mem_cmd       = mem_bus_pkg::bus_none;
        case (state)
            st_ready: begin
                if (req_valid && !lines.hit) begin   // miss
                    lines.capture = 1'b1;
                    state_next    = st_write_back;
                end else if (done) begin
                    state_next = st_flush_scan;
                end
            end
            st_write_back: begin
                // a clean or empty victim needs no store
                if (!lines.victim_dirty) begin
                    state_next = st_fetch;
                end else begin
                    mem_cmd = mem_bus_pkg::bus_store;
                    if (accepted) begin
                        state_next = st_fetch;
                    end
                end
            end
            st_fetch: begin
                mem_cmd = mem_bus_pkg::bus_load;
                if (accepted) begin
                    state_next = st_wait_fill;
                end
            end
            st_wait_fill: begin
                if (mem_tag == kept_tag) begin
                    lines.fill = 1'b1;
                    state_next = st_ready;
                end
            end
            st_flush_scan: begin
                if (lines.victim_dirty) begin
                    state_next = st_flush_store;
                end else if (last) begin
                    state_next = st_finished;
                end else begin
                    step = 1'b1;   // clean line costs one cycle
                end
            end
            st_flush_store: begin
                mem_cmd = mem_bus_pkg::bus_store;
                if (accepted) begin
                    lines.clean = 1'b1;
                    if (last) begin
                        state_next = st_finished;
                    end else begin
                        step       = 1'b1;
                        state_next = st_flush_scan;
                    end
                end
            end
            st_finished: begin
                state_next = st_finished;   // left only by reset
            end
            default: begin
                state_next = st_ready;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state    <= st_ready;
            kept_tag <= '0;
        end else begin
            state <= state_next;
            if (state == st_fetch && accepted) begin
                kept_tag <= mem_response;
            end
        end
    end

    // loads go to the pending block, stores to the selected victim
    assign mem_addr = (state == st_fetch) ? lines.pend_addr : lines.victim_addr;

    assign mem_wdata      = lines.victim_data;   // stable while a store is held
    assign lines.use_walk = state == st_flush_scan || state == st_flush_store
                            || state == st_finished;
    assign stall          = state != st_ready;
    assign flush_finished = state == st_finished;

endmodule

`default_nettype wire

/* rtl/flush_walker.sv */
`timescale 1ns/10ps
`default_nettype none

module flush_walker (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  step,
    output logic [dcache_geom_pkg::idx_bits-1:0]  walk_idx,
    output logic                                  last
);

    always_ff @(posedge clock) begin
        if (reset) begin
            walk_idx <= '0;
        end else if (step) begin
            walk_idx <= walk_idx + 1'b1;   // one line per step
        end
    end

    // final line of the scan
    assign last = walk_idx == dcache_geom_pkg::idx_bits'(dcache_geom_pkg::n_lines - 1);

endmodule

`default_nettype wire

/* rtl/line_store.sv */
`timescale 1ns/10ps
`default_nettype none

module line_store (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  req_valid,
    input  logic                                  req_op,
    input  logic [1:0]                            req_size,
    input  logic [dcache_geom_pkg::xlen-1:0]      req_addr,
    input  logic [dcache_geom_pkg::xlen-1:0]      req_wdata,
    input  logic [dcache_geom_pkg::blk_bits-1:0]  mem_rdata,
    input  logic [dcache_geom_pkg::idx_bits-1:0]  walk_idx,
    output logic                                  resp_valid,
    output logic [dcache_geom_pkg::xlen-1:0]      resp_data,
    line_ctrl_if.store                            lines
);

    dcache_geom_pkg::cache_line_t                line_q [dcache_geom_pkg::n_lines];

    mem_bus_pkg::mem_op_t                        req_op_e;
    mem_bus_pkg::mem_size_t                      req_size_e;
    logic [dcache_geom_pkg::tag_bits-1:0]        req_tag;
    logic [dcache_geom_pkg::idx_bits-1:0]        req_idx;
    dcache_geom_pkg::cache_line_t                req_line;
    logic                                        hit_take;
    dcache_geom_pkg::cache_block_t               hit_blk;

    logic                                        busy;   // miss or flush in progress
    mem_bus_pkg::mem_op_t                        pend_op;
    mem_bus_pkg::mem_size_t                      pend_size;
    logic [dcache_geom_pkg::xlen-1:0]            pend_addr_q;
    logic [dcache_geom_pkg::xlen-1:0]            pend_wdata;
    logic [dcache_geom_pkg::idx_bits-1:0]        pend_idx;
    dcache_geom_pkg::cache_block_t               fill_blk;

    logic [dcache_geom_pkg::idx_bits-1:0]        sel_idx;
    dcache_geom_pkg::cache_line_t                sel_line;

    // write a store into a block through the view of its size
    function automatic dcache_geom_pkg::cache_block_t merge_store(
        input dcache_geom_pkg::cache_block_t              blk,
        input mem_bus_pkg::mem_size_t                     size,
        input logic [dcache_geom_pkg::off_bits-1:0]       off,
        input logic [dcache_geom_pkg::xlen-1:0]           wdata
    );
        dcache_geom_pkg::cache_block_t merged;
        merged = blk;
        case (size)
            mem_bus_pkg::size_byte: merged.bytes[off] = wdata[7:0];
            mem_bus_pkg::size_half: merged.halves[off[dcache_geom_pkg::off_bits-1:1]] = wdata[15:0];
            default:                merged.words[off[dcache_geom_pkg::off_bits-1]] = wdata;
        endcase
        return merged;
    endfunction

    // pick the addressed item and zero-extend it
    function automatic logic [dcache_geom_pkg::xlen-1:0] load_view(
        input dcache_geom_pkg::cache_block_t              blk,
        input mem_bus_pkg::mem_size_t                     size,
        input logic [dcache_geom_pkg::off_bits-1:0]       off
    );
        logic [dcache_geom_pkg::xlen-1:0] data;
        data = '0;
        case (size)
            mem_bus_pkg::size_byte: data[7:0]  = blk.bytes[off];
            mem_bus_pkg::size_half: data[15:0] = blk.halves[off[dcache_geom_pkg::off_bits-1:1]];
            default:                data       = blk.words[off[dcache_geom_pkg::off_bits-1]];
        endcase
        return data;
    endfunction

    assign req_op_e   = mem_bus_pkg::mem_op_t'(req_op);
    assign req_size_e = mem_bus_pkg::mem_size_t'(req_size);
    assign req_tag    = req_addr[dcache_geom_pkg::xlen-1 -: dcache_geom_pkg::tag_bits];
    assign req_idx    = req_addr[dcache_geom_pkg::off_bits +: dcache_geom_pkg::idx_bits];
    assign req_line   = line_q[req_idx];

    assign lines.hit = req_valid && req_line.valid && req_line.tag == req_tag;
    assign hit_take  = lines.hit && !busy && !lines.use_walk;   // only taken while ready

    assign hit_blk = (req_op_e == mem_bus_pkg::mem_write)
                   ? merge_store(req_line.block, req_size_e,
                                 req_addr[dcache_geom_pkg::off_bits-1:0], req_wdata)
                   : req_line.block;

    // returned block with the pending store on top
    assign pend_idx = pend_addr_q[dcache_geom_pkg::off_bits +: dcache_geom_pkg::idx_bits];
    assign fill_blk = (pend_op == mem_bus_pkg::mem_write)
                    ? merge_store(mem_rdata, pend_size,
                                  pend_addr_q[dcache_geom_pkg::off_bits-1:0], pend_wdata)
                    : mem_rdata;

    assign sel_idx  = lines.use_walk ? walk_idx : pend_idx;
    assign sel_line = line_q[sel_idx];

    assign lines.victim_dirty = sel_line.valid && sel_line.dirty;
    assign lines.victim_addr  = {sel_line.tag, sel_idx, {dcache_geom_pkg::off_bits{1'b0}}};
    assign lines.victim_data  = sel_line.block;
    assign lines.pend_addr    = {pend_addr_q[dcache_geom_pkg::xlen-1:dcache_geom_pkg::off_bits],
                                 {dcache_geom_pkg::off_bits{1'b0}}};

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < dcache_geom_pkg::n_lines; i++) begin
                line_q[i].valid <= 1'b0;
                line_q[i].dirty <= 1'b0;
            end
        end else if (lines.fill) begin
            line_q[pend_idx].valid <= 1'b1;
            line_q[pend_idx].dirty <= pend_op == mem_bus_pkg::mem_write;   // clean unless a store merged
            line_q[pend_idx].tag   <= pend_addr_q[dcache_geom_pkg::xlen-1 -: dcache_geom_pkg::tag_bits];
            line_q[pend_idx].block <= fill_blk;
        end else if (hit_take && req_op_e == mem_bus_pkg::mem_write) begin
            line_q[req_idx].dirty <= 1'b1;
            line_q[req_idx].block <= hit_blk;
        end else if (lines.clean) begin
            line_q[sel_idx].dirty <= 1'b0;   // after write-back
        end
    end

    always_ff @(posedge clock) begin
        if (lines.capture) begin
            pend_op     <= req_op_e;
            pend_size   <= req_size_e;
            pend_addr_q <= req_addr;
            pend_wdata  <= req_wdata;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (lines.capture) begin
            busy <= 1'b1;
        end else if (lines.fill) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= hit_take || lines.fill;
        end
    end

    // stores answer with the stored item
    always_ff @(posedge clock) begin
        if (lines.fill) begin
            resp_data <= load_view(fill_blk, pend_size,
                                   pend_addr_q[dcache_geom_pkg::off_bits-1:0]);
        end else if (hit_take) begin
            resp_data <= load_view(hit_blk, req_size_e,
                                   req_addr[dcache_geom_pkg::off_bits-1:0]);
        end
    end

endmodule

`default_nettype wire

/* rtl/dcache.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache (
    input  logic                                  clock,
    input  logic                                  reset,
    // pipeline request
    input  logic                                  req_valid,
    input  logic                                  req_op,
    input  logic [1:0]                            req_size,
    input  logic [dcache_geom_pkg::xlen-1:0]      req_addr,
    input  logic [dcache_geom_pkg::xlen-1:0]      req_wdata,
    // pipeline response
    output logic                                  stall,
    output logic                                  resp_valid,
    output logic [dcache_geom_pkg::xlen-1:0]      resp_data,
    // from memory
    input  logic [mem_bus_pkg::mem_tag_bits-1:0]  mem_response,
    input  logic [mem_bus_pkg::mem_tag_bits-1:0]  mem_tag,
    input  logic [dcache_geom_pkg::blk_bits-1:0]  mem_rdata,
    // to memory
    output logic [1:0]                            mem_cmd,
    output logic [dcache_geom_pkg::xlen-1:0]      mem_addr,
    output logic [dcache_geom_pkg::blk_bits-1:0]  mem_wdata,
    // program end
    input  logic                                  done,
    output logic                                  flush_finished
);

    logic                                  step;
    logic [dcache_geom_pkg::idx_bits-1:0]  walk_idx;
    logic                                  last;

    line_ctrl_if lines ();

    dcache_ctrl i_dcache_ctrl (
        .clock          (clock),
        .reset          (reset),
        .req_valid      (req_valid),
        .done           (done),
        .mem_response   (mem_response),
        .mem_tag        (mem_tag),
        .stall          (stall),
        .mem_cmd        (mem_cmd),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .flush_finished (flush_finished),
        .step           (step),
        .walk_idx       (walk_idx),
        .last           (last),
        .lines          (lines.ctrl)
    );

    flush_walker i_flush_walker (
        .clock    (clock),
        .reset    (reset),
        .step     (step),
        .walk_idx (walk_idx),
        .last     (last)
    );

    line_store i_line_store (
        .clock      (clock),
        .reset      (reset),
        .req_valid  (req_valid),
        .req_op     (req_op),
        .req_size   (req_size),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .mem_rdata  (mem_rdata),
        .walk_idx   (walk_idx),
        .resp_valid (resp_valid),
        .resp_data  (resp_data),
        .lines      (lines.store)
    );

endmodule

`default_nettype wire

/* sim/dcache_sva.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache_sva (
    input  logic        clock,
    input  logic        reset,
    input  logic        stall,
    input  logic        resp_valid,
    input  logic        flush_finished,
    input  logic [3:0]  mem_response,
    input  logic [1:0]  mem_cmd,
    input  logic [31:0] mem_addr,
    input  logic [63:0] mem_wdata
);

    // a command without a response tag stays on the bus
    cmd_held: assert property (@(posedge clock) disable iff (reset)
        (mem_cmd != mem_bus_pkg::bus_none && mem_response == 4'h0)
        |=> ($stable(mem_cmd) && $stable(mem_addr) && $stable(mem_wdata)))
        else $error("bus command changed under back-pressure");

    resp_single: assert property (@(posedge clock) disable iff (reset)
        resp_valid |=> !resp_valid)
        else $error("resp_valid high for more than one cycle");

    flush_sticky: assert property (@(posedge clock) disable iff (reset)
        flush_finished |=> flush_finished)
        else $error("flush_finished fell before reset");

    ready_after_reset: assert property (@(posedge clock)
        $fell(reset) |-> !stall)
        else $error("stall high in the first cycle after reset");

endmodule

`default_nettype wire

/* sim/tb_dcache.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_dcache;

    localparam int max_records = 64;

    logic        clock        = 1'b0;
    logic        reset        = 1'b1;
    logic        req_valid    = 1'b0;
    logic        req_op       = 1'b0;
    logic [1:0]  req_size     = 2'd0;
    logic [31:0] req_addr     = '0;
    logic [31:0] req_wdata    = '0;
    logic        done         = 1'b0;
    logic [3:0]  mem_response = '0;
    logic [3:0]  mem_tag      = '0;
    logic [63:0] mem_rdata    = '0;
    logic        stall;
    logic        resp_valid;
    logic [31:0] resp_data;
    logic [1:0]  mem_cmd;
    logic [31:0] mem_addr;
    logic [63:0] mem_wdata;
    logic        flush_finished;

    // each record is five words of op, size, address, write data and expected
    logic [31:0] patterns [0:5*max_records-1];
    int          cycle_count = 0;
    int          cycle_limit = 0;   // set once the patterns are counted
    int          seed        = 72095;

    // memory model state
    logic [31:0] mem_words [logic [31:0]];   // only words that were stored
    logic [3:0]  next_tag     = 4'h1;
    logic        load_pending = 1'b0;
    logic [31:0] load_addr    = '0;
    logic [3:0]  load_tag     = '0;
    int          load_wait    = 0;

    logic [31:0] prev_addr  = '0;   // block of the previous access
    logic        prev_valid = 1'b0;

    dcache i_dcache (
        .clock          (clock),
        .reset          (reset),
        .req_valid      (req_valid),
        .req_op         (req_op),
        .req_size       (req_size),
        .req_addr       (req_addr),
        .req_wdata      (req_wdata),
        .stall          (stall),
        .resp_valid     (resp_valid),
        .resp_data      (resp_data),
        .mem_response   (mem_response),
        .mem_tag        (mem_tag),
        .mem_rdata      (mem_rdata),
        .mem_cmd        (mem_cmd),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .done           (done),
        .flush_finished (flush_finished)
    );

    bind dcache dcache_sva i_dcache_sva (
        .clock          (clock),
        .reset          (reset),
        .stall          (stall),
        .resp_valid     (resp_valid),
        .flush_finished (flush_finished),
        .mem_response   (mem_response),
        .mem_cmd        (mem_cmd),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata)
    );

    always #20 clock = ~clock;

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s (got %h, expected %h)",
                     $time, what, actual, expected);
            $display("Some tests failed");
            $fatal(1, "mismatch in %s", what);
        end
    endtask

    // untouched words follow the fill rule of the memory
    function automatic logic [31:0] read_word(input logic [31:0] addr);
        logic [31:0] word_addr;
        word_addr = {addr[31:2], 2'b00};
        if (mem_words.exists(word_addr)) begin
            return mem_words[word_addr];
        end
        return word_addr ^ 32'h5a5a0000;
    endfunction

    // present one request, wait for its response and compare
    task automatic run_access(input int rec, input logic op, input logic [1:0] size,
                              input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [31:0] expected);
        int   latency;
        logic same_block;
        same_block = prev_valid && addr[31:3] == prev_addr[31:3];
        while (stall) begin
            @(posedge clock);
        end
        req_valid <= 1'b1;
        req_op    <= op;
        req_size  <= size;
        req_addr  <= addr;
        req_wdata <= wdata;
        @(posedge clock);
        check(32'(stall), 32'd0, $sformatf("stall with request %0d presented", rec));
        req_valid <= 1'b0;   // taken on this edge
        latency = 0;
        do begin
            @(posedge clock);
            latency++;
        end while (!resp_valid);
        check(resp_data, expected, $sformatf("response data of pattern %0d", rec));
        if (same_block) begin
            check(latency, 32'd1, $sformatf("hit latency of pattern %0d", rec));
        end
        prev_addr  = addr;
        prev_valid = 1'b1;
    endtask

    task automatic flush_cache();
        done <= 1'b1;   // held to the end of the run
        do begin
            @(posedge clock);
        end while (!flush_finished);
        check(32'(stall), 32'd1, "stall at the end of the flush");
        check(32'(mem_cmd), 32'd0, "bus command at the end of the flush");
    endtask

    // memory model with random back-pressure and delayed load data
    always @(posedge clock) begin
        if (reset) begin
            mem_response <= '0;
            mem_tag      <= '0;
            mem_rdata    <= '0;
            load_pending = 1'b0;
            next_tag     = 4'h1;
        end else begin
            mem_tag <= '0;
            if (load_pending) begin
                load_wait = load_wait - 1;
                if (load_wait == 0) begin
                    mem_tag      <= load_tag;
                    mem_rdata    <= {read_word(load_addr + 32'd4), read_word(load_addr)};
                    load_pending = 1'b0;
                end
            end
            if (mem_cmd != mem_bus_pkg::bus_none && mem_response != 4'h0) begin
                check(32'(mem_addr[2:0]), 32'd0, "block alignment of bus address");
                if (mem_cmd == mem_bus_pkg::bus_store) begin
                    mem_words[{mem_addr[31:3], 3'b000}] = mem_wdata[31:0];
                    mem_words[{mem_addr[31:3], 3'b100}] = mem_wdata[63:32];
                end else begin
                    load_pending = 1'b1;
                    load_addr    = {mem_addr[31:3], 3'b000};
                    load_tag     = mem_response;
                    load_wait    = 3 + int'($unsigned($random(seed)) % 4);   // 3 to 6
                end
                next_tag = (next_tag == 4'hf) ? 4'h1 : next_tag + 4'h1;
            end
            mem_response <= ($unsigned($random(seed)) % 4 != 0) ? next_tag : 4'h0;
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Some tests failed");
            $fatal(1, "timeout, the run did not finish within %0d cycles", cycle_limit);
        end
    end

    initial begin
        int         n_records;
        int         base;
        int         r;
        logic [3:0] op;
        n_records = 0;
        $readmemh("sim/dcache_patterns.txt", patterns);
        while (n_records < max_records && patterns[5*n_records][3:0] != 4'hf) begin
            n_records++;
        end
        cycle_limit = 200 * (n_records + 1);

        repeat (5) @(posedge clock);
        reset <= 1'b0;
        @(posedge clock);
        check(32'(stall), 32'd0, "stall after reset");
        check(32'(resp_valid), 32'd0, "resp_valid after reset");
        check(32'(flush_finished), 32'd0, "flush_finished after reset");
        check(32'(mem_cmd), 32'd0, "bus command after reset");

        for (r = 0; r < n_records; r++) begin
            base = 5 * r;
            op   = patterns[base][3:0];
            case (op)
                4'h0, 4'h1: begin
                    run_access(r, op[0], patterns[base+1][1:0], patterns[base+2],
                               patterns[base+3], patterns[base+4]);
                end
                4'h2: begin
                    flush_cache();
                end
                4'h3: begin
                    check(read_word(patterns[base+2]), patterns[base+4],
                          $sformatf("memory word at %h", patterns[base+2]));
                end
                default: begin
                    $display("Some tests failed");
                    $fatal(1, "pattern %0d holds the unknown operation %h", r, op);
                end
            endcase
        end

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* sim/dcache_patterns.txt */
// op size addr wdata expect, op 0 load, 1 store, 2 done and flush
// 3 memory word check (addr, expect), f end of patterns
0 2 00001040 00000000 5a5a1040
0 2 00001044 00000000 5a5a1044
1 0 00001041 000000a5 000000a5
0 2 00001040 00000000 5a5aa540
1 1 00001046 0000beef 0000beef
0 2 00001044 00000000 beef1044
0 1 00001042 00000000 00005a5a
0 0 00001047 00000000 000000be
1 2 00003088 12345678 12345678
0 2 0000308c 00000000 5a5a308c
0 0 0000308a 00000000 00000034
0 2 00002040 00000000 5a5a2040
3 0 00001040 00000000 5a5aa540
3 0 00001044 00000000 beef1044
0 2 00001044 00000000 beef1044
0 0 00001041 00000000 000000a5
1 1 000040f8 0000cafe 0000cafe
1 0 00000003 00000077 00000077
0 2 00000000 00000000 775a0000
1 2 00001044 0badf00d 0badf00d
2 0 00000000 00000000 00000000
3 0 00001040 00000000 5a5aa540
3 0 00001044 00000000 0badf00d
3 0 00002040 00000000 5a5a2040
3 0 00003088 00000000 12345678
3 0 0000308c 00000000 5a5a308c
3 0 000040f8 00000000 5a5acafe
3 0 000040fc 00000000 5a5a40fc
3 0 00000000 00000000 775a0000
3 0 00000004 00000000 5a5a0004
f 0 00000000 00000000 00000000

/* flist.f */
rtl/dcache_geom_pkg.sv
rtl/mem_bus_pkg.sv
rtl/line_ctrl_if.sv
rtl/dcache_ctrl.sv
rtl/flush_walker.sv
rtl/line_store.sv
rtl/dcache.sv
sim/dcache_sva.sv
sim/tb_dcache.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_dcache
FLIST      := flist.f
BUILD_DIR  := obj_dir
VFLAGS     := --binary --timing --assert -j 0 --Mdir $(BUILD_DIR) --top-module $(TOP)
LINT_FLAGS := --lint-only --timing --assert --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR)
